// File: compile.f
user_io_pkg.sv
spi_slave_port.sv
io_cmd_decoder.sv
ps2_kbd_tx.sv
user_io_top.sv
tb_clk_gen.sv
tb_user_io.sv

// File: io_cmd_decoder.sv
//**************************************************************************
// clk_sys side of the user I/O slave: takes received SPI bytes across
// and decodes the write commands into registers, key events and FIFO writes
//**************************************************************************

module io_cmd_decoder (
	input  logic                    clk_sys,
	input  logic                    SPI_SS_IO,
	input  user_io_pkg::spi_byte_t  rx_i,
	input  logic                    xfer_end_i,
	input  logic                    kbd_fifo_ready_i,
	output user_io_pkg::but_sw_t    but_sw_o,
	output user_io_pkg::joy_t       joystick_0_o,
	output user_io_pkg::joy_t       joystick_1_o,
	output logic [63:0]             status_o,
	output user_io_pkg::key_event_t key_o,
	output logic                    key_strobe_o,
	output logic                    kbd_wr_o,
	output logic [7:0]              kbd_byte_o
);
	import user_io_pkg::*;

	logic [2:0]            tgl_sync;
	logic [1:0]            end_sync;
	logic [BYTE_CNT_W-1:0] byte_cnt;
	logic [BYTE_CNT_W-1:0] byte_idx;
	logic                  fifo_ok;
	logic                  new_byte;
	logic                  cmd_byte;
	logic                  data_byte;
	logic                  first_key;
	logic                  is_prefix;
	logic                  key_hit;
	logic [7:0]            acmd;
	logic                  key_pressed_r;
	logic                  key_ext_r;

	// decoded registers keep their value across transfers
	but_sw_t        but_sw_q = '0;
	joy_t           joy_q [NUM_JOYSTICKS] = '{default: '0};
	logic [7:0][7:0] status_q = '0;
	key_event_t     key_q = '0;
	logic [7:0]     kbd_byte_q = '0;

	// a toggle change after the two sync flops marks one byte
	assign new_byte  = tgl_sync[2] ^ tgl_sync[1];
	assign cmd_byte  = new_byte && !end_sync[1] && (byte_cnt == '0);
	assign data_byte = new_byte && !end_sync[1] && (byte_cnt != '0);
	assign byte_idx  = byte_cnt - 1'b1;

	assign first_key = (byte_cnt == BYTE_CNT_W'(1));
	assign is_prefix = (rx_i.data == KBD_EXT_PREFIX) || (rx_i.data == KBD_BREAK_PREFIX);
	assign key_hit   = data_byte && (acmd == CMD_KBD) && !is_prefix;

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			tgl_sync     <= '0;
			end_sync     <= '1;
			key_strobe_o <= 1'b0;
			kbd_wr_o     <= 1'b0;
		end else begin
			tgl_sync     <= {tgl_sync[1:0], rx_i.tgl};
			end_sync     <= {end_sync[0], xfer_end_i};
			key_strobe_o <= key_hit;
			kbd_wr_o     <= data_byte && (acmd == CMD_KBD) && fifo_ok;
		end
	end

	// payload position and FIFO permission, cleared at the end of a transfer
	always_ff @(posedge clk_sys) begin
		if (end_sync[1]) begin
			byte_cnt <= '0;
			fifo_ok  <= 1'b0;
		end else if (new_byte) begin
			if (!(&byte_cnt))
				byte_cnt <= byte_cnt + 1'b1;
			// only accept a key packet that fits completely
			if (byte_cnt == '0 && rx_i.data == CMD_KBD)
				fifo_ok <= kbd_fifo_ready_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cmd_byte)
			acmd <= rx_i.data;
		if (data_byte) begin
			case (acmd)
				CMD_BUT_SW: but_sw_q <= but_sw_t'(rx_i.data);
				CMD_STATUS64: begin
					if (byte_cnt <= BYTE_CNT_W'(8))
						status_q[byte_idx[2:0]] <= rx_i.data;
				end
				CMD_KBD: begin
					kbd_byte_q <= rx_i.data;
					if (first_key) begin
						key_ext_r     <= 1'b0;
						key_pressed_r <= 1'b1;
					end
					if (rx_i.data == KBD_EXT_PREFIX)
						key_ext_r <= 1'b1;
					else if (rx_i.data == KBD_BREAK_PREFIX)
						key_pressed_r <= 1'b0;
					else
						key_q <= '{code: rx_i.data,
							pressed: key_pressed_r || first_key,
							extended: key_ext_r && !first_key};
				end
				default: begin
					// joystick commands are consecutive codes
					for (int j = 0; j < NUM_JOYSTICKS; j++) begin
						if (acmd == CMD_JOY0 + 8'(j) && byte_cnt <= BYTE_CNT_W'(4))
							joy_q[j][byte_idx[1:0]] <= rx_i.data;
					end
				end
			endcase
		end
	end

	assign but_sw_o     = but_sw_q;
	assign joystick_0_o = joy_q[0];
	assign joystick_1_o = joy_q[1];
	assign status_o     = status_q;
	assign key_o        = key_q;
	assign kbd_byte_o   = kbd_byte_q;

endmodule

// File: ps2_kbd_tx.sv
//**************************************************************************
// keyboard byte FIFO and PS/2 device-side transmitter, sending each
// scan code byte as an 11-bit frame on a clock divided from clk_sys
//**************************************************************************

module ps2_kbd_tx (
	input  logic       clk_sys,
	input  logic       kbd_wr_i,
	input  logic [7:0] kbd_byte_i,
	output logic       fifo_ready_o,
	output logic       ps2_clk_o,
	output logic       ps2_data_o
);
	import user_io_pkg::*;

	logic [7:0]               fifo_mem [2**PS2_FIFO_BITS];
	logic [PS2_FIFO_BITS-1:0] wptr = '0;
	logic [PS2_FIFO_BITS-1:0] rptr = '0;
	logic [PS2_FIFO_BITS:0]   used_cnt;
	logic [PS2_FIFO_BITS:0]   free_cnt;
	logic                     fifo_empty;

	logic [PS2_DIV_W-1:0] div_cnt = '0;
	logic                 div_wrap;
	logic                 ps2_clk_q = 1'b0;
	logic                 clk_rise;

	logic [3:0] tx_state = '0;
	logic [7:0] tx_shift = '0;
	logic       tx_parity = 1'b1;
	logic       data_q = 1'b1;

	assign used_cnt   = {1'b0, wptr - rptr};
	assign free_cnt   = {1'b1, {PS2_FIFO_BITS{1'b0}}} - used_cnt;
	assign fifo_empty = (wptr == rptr);

	// at least 4 entries free
	assign fifo_ready_o = (free_cnt[PS2_FIFO_BITS:2] != '0);

	always_ff @(posedge clk_sys) begin
		if (kbd_wr_i) begin
			fifo_mem[wptr] <= kbd_byte_i;
			wptr           <= wptr + 1'b1;
		end
	end

	// PS/2 clock, one toggle every PS2_CLK_DIV cycles
	assign div_wrap = (div_cnt == PS2_DIV_W'(PS2_CLK_DIV - 1));
	assign clk_rise = div_wrap && !ps2_clk_q;

	always_ff @(posedge clk_sys) begin
		if (div_wrap) begin
			div_cnt   <= '0;
			ps2_clk_q <= ~ps2_clk_q;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// state 0 idle, 1-8 data bits, 9 parity, 10 stop, 11 stop held
	always_ff @(posedge clk_sys) begin
		if (clk_rise) begin
			case (tx_state)
				4'd0: begin
					if (!fifo_empty) begin
						tx_shift  <= fifo_mem[rptr];
						// odd parity over the data bits
						tx_parity <= ~^fifo_mem[rptr];
						rptr      <= rptr + 1'b1;
						// start bit
						data_q    <= 1'b0;
						tx_state  <= 4'd1;
					end
				end
				4'd9: begin
					data_q   <= tx_parity;
					tx_state <= 4'd10;
				end
				4'd10: begin
					data_q   <= 1'b1;
					tx_state <= 4'd11;
				end
				4'd11: tx_state <= 4'd0;
				default: begin
					// data bits LSB first
					data_q   <= tx_shift[0];
					tx_shift <= {1'b0, tx_shift[7:1]};
					tx_state <= tx_state + 4'd1;
				end
			endcase
		end
	end

	// clock held high between frames
	assign ps2_clk_o  = ps2_clk_q || (tx_state == 4'd0);
	assign ps2_data_o = data_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# build the user I/O testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/1ps -Wno-fatal --top-module tb_user_io -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build did not complete"
	exit 1
fi

./obj_dir/Vtb_user_io > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0

// File: spi_slave_port.sv
//**************************************************************************
// SPI clock domain of the user I/O slave: assembles MOSI bytes, hands
// them to clk_sys by a toggle and shifts the reply byte out on MISO
//**************************************************************************

module spi_slave_port (
	input  logic                   spi_clk_i,
	input  logic                   SPI_SS_IO,
	input  logic                   spi_mosi_i,
	output logic                   spi_miso_o,
	output user_io_pkg::spi_byte_t rx_o,
	output logic                   xfer_end_o
);
	import user_io_pkg::*;

	logic [2:0]            bit_cnt;
	logic [BYTE_CNT_W-1:0] byte_cnt;
	logic [6:0]            sbuf;
	logic [7:0]            cmd_q;
	logic [7:0]            rx_data_q;
	logic                  rx_tgl_q;
	logic [7:0]            tx_byte_q;
	logic [7:0]            rx_byte;
	logic [7:0]            cur_cmd;
	logic [7:0]            next_tx;

	// complete byte as seen on the rising edge of bit 7
	assign rx_byte = {sbuf, spi_mosi_i};

	// the command byte itself selects the reply to byte 1
	assign cur_cmd = (byte_cnt == '0) ? rx_byte : cmd_q;

	always_comb begin
		next_tx = 8'h00;
		if (cur_cmd == CMD_FEATURES) begin
			case (byte_cnt)
				BYTE_CNT_W'(0): next_tx = CMD_FEATURES;
				BYTE_CNT_W'(1): next_tx = CORE_FEATURES[31:24];
				BYTE_CNT_W'(2): next_tx = CORE_FEATURES[23:16];
				BYTE_CNT_W'(3): next_tx = CORE_FEATURES[15:8];
				BYTE_CNT_W'(4): next_tx = CORE_FEATURES[7:0];
				default: next_tx = 8'h00;
			endcase
		end
	end

	always_ff @(posedge spi_clk_i or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt    <= '0;
			byte_cnt   <= '0;
			rx_tgl_q   <= 1'b0;
			xfer_end_o <= 1'b1;
			// reply to the next command byte
			tx_byte_q  <= CORE_TYPE;
		end else begin
			xfer_end_o <= 1'b0;
			bit_cnt    <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				if (!(&byte_cnt))
					byte_cnt <= byte_cnt + 1'b1;
				rx_tgl_q  <= ~rx_tgl_q;
				tx_byte_q <= next_tx;
			end
		end
	end

	// shift register and captured bytes
	always_ff @(posedge spi_clk_i) begin
		sbuf <= rx_byte[6:0];
		if (bit_cnt == 3'd7) begin
			rx_data_q <= rx_byte;
			if (byte_cnt == '0)
				cmd_q <= rx_byte;
		end
	end

	// MSB first, clock idles high so bit 7 leaves on the first falling edge
	always_ff @(negedge spi_clk_i or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			spi_miso_o <= 1'b0;
		else
			spi_miso_o <= tx_byte_q[~bit_cnt];
	end

	assign rx_o = '{tgl: rx_tgl_q, data: rx_data_q};

endmodule

// File: tb_clk_gen.sv
//**************************************************************************
// testbench clock and reset source, clk_sys at 8 ns with reset held
// high for the first few cycles
//**************************************************************************

module tb_clk_gen (
	output logic clk_sys_o,
	output logic reset_o
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk_sys_o = 1'b0;
		forever #(HALF_PERIOD) clk_sys_o = ~clk_sys_o;
	end

	// release on a falling edge, away from the DUT clock edge
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys_o);
		@(negedge clk_sys_o);
		reset_o = 1'b0;
	end

endmodule

// File: tb_user_io.sv
//**************************************************************************
// testbench of the SPI user I/O slave that bit-bangs SPI transfers,
// watches the PS/2 keyboard line and checks the decoded outputs
//**************************************************************************

module tb_user_io;
	timeunit 1ns;
	timeprecision 1ps;
	import user_io_pkg::*;

	// SPI half period in clk_sys cycles
	localparam int SPI_HALF     = 8;
	// the five tests need about 25000 cycles, mostly PS/2 frames
	localparam int MAX_CYCLES   = 60000;
	localparam int PS2_WAIT_MAX = 20000;

	logic        clk_sys;
	logic        reset;
	logic        ss_ctl;
	logic        SPI_SS_IO;
	logic        spi_clk;
	logic        spi_mosi;
	logic        spi_miso;
	but_sw_t     but_sw;
	joy_t        joystick_0;
	joy_t        joystick_1;
	logic [63:0] status;
	key_event_t  key;
	logic        key_strobe;
	logic        ps2_kbd_clk;
	logic        ps2_kbd_data;

	logic [7:0]  mosi_q [$];
	logic [7:0]  miso_q [$];
	logic [7:0]  ps2_rx_q [$];
	key_event_t  key_seen [$];
	logic [10:0] ps2_frame;
	int          ps2_bit_cnt = 0;
	int          err_cnt = 0;
	int          tests_run = 0;
	int          tests_bad = 0;
	int          cycle_cnt = 0;

	// deselect doubles as the DUT reset
	assign SPI_SS_IO = reset || ss_ctl;

	tb_clk_gen tb_clk_gen_inst (
		.clk_sys_o (clk_sys),
		.reset_o   (reset)
	);

	user_io_top user_io_top_inst (
		.clk_sys        (clk_sys),
		.SPI_SS_IO      (SPI_SS_IO),
		.spi_clk_i      (spi_clk),
		.spi_mosi_i     (spi_mosi),
		.spi_miso_o     (spi_miso),
		.but_sw_o       (but_sw),
		.joystick_0_o   (joystick_0),
		.joystick_1_o   (joystick_1),
		.status_o       (status),
		.key_o          (key),
		.key_strobe_o   (key_strobe),
		.ps2_kbd_clk_o  (ps2_kbd_clk),
		.ps2_kbd_data_o (ps2_kbd_data)
	);

	task automatic check_eq(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("ERR at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		tests_run++;
		if (err_cnt != errs_at_start)
			tests_bad++;
		$display("test %s done with %0d errors", name, err_cnt - errs_at_start);
	endtask

	task automatic load_cmd(input logic [7:0] cmd);
		mosi_q.delete();
		mosi_q.push_back(cmd);
	endtask

	// mode 3 SPI, MISO read just before each rising SPI_CLK edge
	task automatic spi_transfer();
		logic [7:0] rx_byte;
		miso_q.delete();
		@(negedge clk_sys);
		ss_ctl = 1'b0;
		wait_cycles(SPI_HALF);
		foreach (mosi_q[i]) begin
			for (int b = 7; b >= 0; b--) begin
				spi_clk  = 1'b0;
				spi_mosi = mosi_q[i][b];
				wait_cycles(SPI_HALF);
				rx_byte[b] = spi_miso;
				spi_clk    = 1'b1;
				wait_cycles(SPI_HALF);
			end
			miso_q.push_back(rx_byte);
		end
		ss_ctl   = 1'b1;
		spi_mosi = 1'b0;
		wait_cycles(SPI_HALF);
	endtask

	// one 11-bit frame per 11 falling edges of the PS/2 clock
	always @(negedge ps2_kbd_clk) begin
		ps2_frame[ps2_bit_cnt] = ps2_kbd_data;
		if (ps2_bit_cnt == 10) begin
			check_eq("ps2 start bit", 0, ps2_frame[0]);
			check_eq("ps2 odd parity", 1, ^ps2_frame[9:1]);
			check_eq("ps2 stop bit", 1, ps2_frame[10]);
			ps2_rx_q.push_back(ps2_frame[8:1]);
			ps2_bit_cnt = 0;
		end else begin
			ps2_bit_cnt++;
		end
	end

	always @(negedge clk_sys) begin
		if (key_strobe)
			key_seen.push_back(key);
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: tests still running after %0d clk_sys cycles", cycle_cnt);
			$display("tests failed");
			$finish;
		end
	end

	task automatic test_features();
		int         errs_at_start;
		logic [7:0] exp_q [$];
		errs_at_start = err_cnt;
		exp_q.push_back(CORE_TYPE);
		exp_q.push_back(CMD_FEATURES);
		for (int k = 0; k < 4; k++)
			exp_q.push_back(CORE_FEATURES[31 - 8 * k -: 8]);
		load_cmd(CMD_FEATURES);
		repeat (5) mosi_q.push_back(8'h00);
		spi_transfer();
		for (int i = 0; i < 6 && i < miso_q.size(); i++)
			check_eq($sformatf("spi_miso_o byte %0d", i), exp_q[i], miso_q[i]);
		end_test("features", errs_at_start);
	endtask

	task automatic test_but_sw();
		int         errs_at_start;
		logic [7:0] b;
		errs_at_start = err_cnt;
		b = 8'($urandom);
		load_cmd(CMD_BUT_SW);
		mosi_q.push_back(b);
		spi_transfer();
		check_eq("but_sw_o", b, but_sw);
		check_eq("but_sw_o.buttons", b[1:0], but_sw.buttons);
		check_eq("but_sw_o.switches", b[3:2], but_sw.switches);
		check_eq("but_sw_o.scandoubler_disable", b[4], but_sw.scandoubler_disable);
		check_eq("but_sw_o.ypbpr", b[5], but_sw.ypbpr);
		check_eq("but_sw_o.no_csync", b[6], but_sw.no_csync);
		end_test("but_sw", errs_at_start);
	endtask

	// four random bytes low first, then a fifth that must be dropped
	task automatic write_joystick(input logic [7:0] cmd, output logic [31:0] word);
		logic [7:0] b;
		load_cmd(cmd);
		for (int i = 0; i < 4; i++) begin
			b = 8'($urandom);
			word[8 * i +: 8] = b;
			mosi_q.push_back(b);
		end
		mosi_q.push_back(~word[7:0]);
		spi_transfer();
	endtask

	task automatic test_joysticks();
		int          errs_at_start;
		logic [31:0] exp0;
		logic [31:0] exp1;
		errs_at_start = err_cnt;
		// joystick 1 has not been written since power-up
		exp1 = 32'h0;
		write_joystick(CMD_JOY0, exp0);
		check_eq("joystick_0_o", exp0, joystick_0);
		check_eq("joystick_1_o", exp1, joystick_1);
		write_joystick(CMD_JOY1, exp1);
		check_eq("joystick_1_o", exp1, joystick_1);
		check_eq("joystick_0_o", exp0, joystick_0);
		end_test("joysticks", errs_at_start);
	endtask

	task automatic test_status();
		int          errs_at_start;
		logic [63:0] exp_word;
		logic [7:0]  b;
		errs_at_start = err_cnt;
		load_cmd(CMD_STATUS64);
		for (int i = 0; i < 8; i++) begin
			b = 8'($urandom);
			exp_word[8 * i +: 8] = b;
			mosi_q.push_back(b);
		end
		spi_transfer();
		check_eq("status_o", exp_word, status);
		end_test("status64", errs_at_start);
	endtask

	task automatic test_keyboard();
		int         errs_at_start;
		int         wait_cnt;
		int         low_cnt;
		logic [7:0] ps2_exp [6];
		logic [7:0] exp_code [3];
		logic       exp_pressed [3];
		logic       exp_ext [3];
		errs_at_start = err_cnt;
		ps2_exp     = '{8'h1c, 8'he0, 8'h75, 8'he0, 8'hf0, 8'h75};
		exp_code    = '{8'h1c, 8'h75, 8'h75};
		exp_pressed = '{1'b1, 1'b1, 1'b0};
		exp_ext     = '{1'b0, 1'b1, 1'b1};
		key_seen.delete();
		ps2_rx_q.delete();
		load_cmd(CMD_KBD);
		mosi_q.push_back(8'h1c);
		spi_transfer();
		load_cmd(CMD_KBD);
		mosi_q.push_back(KBD_EXT_PREFIX);
		mosi_q.push_back(8'h75);
		spi_transfer();
		load_cmd(CMD_KBD);
		mosi_q.push_back(KBD_EXT_PREFIX);
		mosi_q.push_back(KBD_BREAK_PREFIX);
		mosi_q.push_back(8'h75);
		spi_transfer();
		check_eq("key strobe count", 3, key_seen.size());
		for (int i = 0; i < 3 && i < key_seen.size(); i++) begin
			check_eq($sformatf("key_o.code %0d", i), exp_code[i], key_seen[i].code);
			check_eq($sformatf("key_o.pressed %0d", i), exp_pressed[i], key_seen[i].pressed);
			check_eq($sformatf("key_o.extended %0d", i), exp_ext[i], key_seen[i].extended);
		end
		wait_cnt = 0;
		while (ps2_rx_q.size() < 6 && wait_cnt < PS2_WAIT_MAX) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (ps2_rx_q.size() < 6) begin
			$display("PS/2 monitor received only %0d of 6 keyboard frames", ps2_rx_q.size());
			err_cnt++;
		end
		for (int i = 0; i < 6 && i < ps2_rx_q.size(); i++)
			check_eq($sformatf("ps2 frame %0d", i), ps2_exp[i], ps2_rx_q[i]);
		// after the stop bit the clock must return high and stay there
		wait_cycles(3 * PS2_CLK_DIV);
		low_cnt = 0;
		for (int i = 0; i < 4 * PS2_CLK_DIV; i++) begin
			@(negedge clk_sys);
			if (ps2_kbd_clk !== 1'b1)
				low_cnt++;
		end
		check_eq("ps2_kbd_clk_o low cycles while idle", 0, low_cnt);
		check_eq("ps2_kbd_data_o idle", 1, ps2_kbd_data);
		check_eq("ps2 frame count", 6, ps2_rx_q.size());
		end_test("keyboard", errs_at_start);
	endtask

	initial begin
		ss_ctl   = 1'b1;
		spi_clk  = 1'b1;
		spi_mosi = 1'b0;
		void'($urandom(5));
		wait (reset == 1'b0);
		wait_cycles(4);
		test_features();
		test_but_sw();
		test_joysticks();
		test_status();
		test_keyboard();
		$display("%0d tests run, %0d with errors, %0d errors in total",
			tests_run, tests_bad, err_cnt);
		if (err_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: user_io_pkg.sv
//**************************************************************************
// shared command codes, widths and bus types of the I/O controller link
// imported by every RTL block of the SPI user I/O slave
//**************************************************************************

package user_io_pkg;

	// write commands from the I/O controller
	localparam logic [7:0] CMD_BUT_SW   = 8'h01;
	localparam logic [7:0] CMD_KBD      = 8'h05;
	localparam logic [7:0] CMD_STATUS64 = 8'h1e;
	localparam logic [7:0] CMD_JOY0     = 8'h60;
	localparam logic [7:0] CMD_JOY1     = 8'h61;

	// read command, echoed back before the feature bytes
	localparam logic [7:0] CMD_FEATURES = 8'h80;

	// returned on MISO while the command byte is shifted in
	localparam logic [7:0] CORE_TYPE = 8'ha4;

	// sent MSB first after the echo byte
	localparam logic [31:0] CORE_FEATURES = 32'h12345678;

	// scan code prefixes
	localparam logic [7:0] KBD_EXT_PREFIX   = 8'he0;
	localparam logic [7:0] KBD_BREAK_PREFIX = 8'hf0;

	// byte counter saturates at all ones
	localparam int BYTE_CNT_W = 4;

	// clk_sys cycles per PS/2 clock half period
	localparam int PS2_CLK_DIV = 100;
	localparam int PS2_DIV_W   = $clog2(PS2_CLK_DIV);

	// keyboard FIFO holds 2**PS2_FIFO_BITS bytes
	localparam int PS2_FIFO_BITS = 4;

	localparam int NUM_JOYSTICKS = 2;

	// joystick word, byte 0 is the first payload byte
	typedef logic [3:0][7:0] joy_t;

	typedef struct packed {
		logic       spare;
		logic       no_csync;
		logic       ypbpr;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} but_sw_t;

	// toggle flips once per received byte
	typedef struct packed {
		logic       tgl;
		logic [7:0] data;
	} spi_byte_t;

	typedef struct packed {
		logic [7:0] code;
		logic       pressed;
		logic       extended;
	} key_event_t;

endpackage

// File: user_io_top.sv
//**************************************************************************
// top level of the SPI user I/O slave, joining the SPI port, the command
// decoder and the PS/2 keyboard transmitter to the pins
//**************************************************************************

module user_io_top (
	input  logic                    clk_sys,
	input  logic                    SPI_SS_IO,
	input  logic                    spi_clk_i,
	input  logic                    spi_mosi_i,
	output logic                    spi_miso_o,
	output user_io_pkg::but_sw_t    but_sw_o,
	output user_io_pkg::joy_t       joystick_0_o,
	output user_io_pkg::joy_t       joystick_1_o,
	output logic [63:0]             status_o,
	output user_io_pkg::key_event_t key_o,
	output logic                    key_strobe_o,
	output logic                    ps2_kbd_clk_o,
	output logic                    ps2_kbd_data_o
);
	import user_io_pkg::*;

	spi_byte_t  rx;
	logic       xfer_end;
	logic       kbd_wr;
	logic [7:0] kbd_byte;
	logic       kbd_fifo_ready;

	spi_slave_port spi_slave_port_inst (
		.spi_clk_i  (spi_clk_i),
		.SPI_SS_IO  (SPI_SS_IO),
		.spi_mosi_i (spi_mosi_i),
		.spi_miso_o (spi_miso_o),
		.rx_o       (rx),
		.xfer_end_o (xfer_end)
	);

	io_cmd_decoder io_cmd_decoder_inst (
		.clk_sys          (clk_sys),
		.SPI_SS_IO        (SPI_SS_IO),
		.rx_i             (rx),
		.xfer_end_i       (xfer_end),
		.kbd_fifo_ready_i (kbd_fifo_ready),
		.but_sw_o         (but_sw_o),
		.joystick_0_o     (joystick_0_o),
		.joystick_1_o     (joystick_1_o),
		.status_o         (status_o),
		.key_o            (key_o),
		.key_strobe_o     (key_strobe_o),
		.kbd_wr_o         (kbd_wr),
		.kbd_byte_o       (kbd_byte)
	);

	ps2_kbd_tx ps2_kbd_tx_inst (
		.clk_sys      (clk_sys),
		.kbd_wr_i     (kbd_wr),
		.kbd_byte_i   (kbd_byte),
		.fifo_ready_o (kbd_fifo_ready),
		.ps2_clk_o    (ps2_kbd_clk_o),
		.ps2_data_o   (ps2_kbd_data_o)
	);

endmodule
